// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_mem_subsys
FILELIST  := mem_subsys.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/addr_trans.sv
`timescale 1ns/1ns

module addr_trans import cpu_pkg::*; (
    input  logic       en,
    input  u32_t       va,
    input  byte_type_t byte_type,
    input  csr_t       rd_csr,
    output u32_t       pa,
    output excp_pass_t excp
);

    logic hit0, hit1;
    logic misalign;

    function automatic logic win_hit(input dmw_t dmw, input logic [2:0] seg);
        return dmw.plv0 && (dmw.vseg == seg);
    endfunction

    assign hit0 = win_hit(rd_csr.dmw0, va[31:29]);
    assign hit1 = win_hit(rd_csr.dmw1, va[31:29]);

    // dmw0 has priority when both windows match
    always_comb begin
        if (rd_csr.da) begin
            pa = va;
        end else if (hit0) begin
            pa = {rd_csr.dmw0.pseg, va[28:0]};
        end else if (hit1) begin
            pa = {rd_csr.dmw1.pseg, va[28:0]};
        end else begin
            pa = va;  // unmapped, flagged below
        end
    end

    always_comb begin
        case (byte_type)
            HALF_WORD: misalign = va[0];
            WORD:      misalign = |va[1:0];
            default:   misalign = 1'b0;
        endcase
    end

    always_comb begin
        excp.valid = 1'b0;
        excp.ecode = ECODE_NONE;
        excp.badv  = va;
        if (en) begin
            if (misalign) begin
                excp.valid = 1'b1;
                excp.ecode = ECODE_ALE;
            end else if (!rd_csr.da && !hit0 && !hit1) begin
                excp.valid = 1'b1;
                excp.ecode = ECODE_ADEM;
            end
        end
    end

endmodule

// File: hdl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data memory geometry
// the array is indexed by pa[DRAM_AW+1:2] and higher address bits wrap
`define DRAM_WORDS 256
`define DRAM_AW    8

// architectural register file index width
`define REG_AW     5

`endif

// File: hdl/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [31:0]         u32_t;
    typedef logic [`REG_AW-1:0]  reg_idx_t;

    typedef enum logic [1:0] {
        BYTE      = 2'd0,
        HALF_WORD = 2'd1,
        WORD      = 2'd2
    } byte_type_t;

    // loongarch ecode numbering
    typedef enum logic [5:0] {
        ECODE_NONE = 6'h00,
        ECODE_ADEM = 6'h08,  // no mapping for the address
        ECODE_ALE  = 6'h09   // misaligned access
    } ecode_t;

    typedef enum logic [1:0] {
        DC_NOP = 2'd0,
        DC_R   = 2'd1,
        DC_W   = 2'd2
    } dc_op_t;

    // direct mapping window
    typedef struct packed {
        logic       plv0;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        logic da;
        dmw_t dmw0;
        dmw_t dmw1;
    } csr_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        u32_t       ex_out;    // address for memory ops, alu result otherwise
        u32_t       rkd_data;  // store data
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_t byte_type;
        logic       is_wr_rd;
        logic       is_wr_rd_pc_plus4;
        u32_t       pc_plus4;
        reg_idx_t   rd;
    } execute_memory1_pass_t;

    typedef struct packed {
        logic   valid;
        ecode_t ecode;
        u32_t   badv;
    } excp_pass_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        u32_t       ex_out;
        logic [1:0] addr_low;
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_t byte_type;
        logic       is_wr_rd;
        logic       is_wr_rd_pc_plus4;
        u32_t       pc_plus4;
        reg_idx_t   rd;
    } memory1_memory2_pass_t;

    typedef struct packed {
        dc_op_t     op;
        byte_type_t byte_type;
        u32_t       pa;
        u32_t       wdata;  // already placed in its byte lanes
    } dcache_req_t;

    typedef struct packed {
        logic     valid;
        u32_t     pc;
        reg_idx_t rd;
        logic     is_wr_rd;
        u32_t     wr_data;
    } wb_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
    } load_use_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        u32_t     data;
    } forward_req_t;

endpackage

// File: hdl/data_ram.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module data_ram import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  dcache_req_t req,
    output logic        busy,
    output u32_t        rdata
);

    u32_t mem [`DRAM_WORDS];

    logic [`DRAM_AW-1:0] idx;
    logic [3:0]          be;

    assign idx = req.pa[`DRAM_AW+1:2];  // upper bits wrap

    always_comb begin
        be = 4'b0000;
        case (req.byte_type)
            BYTE:      be[req.pa[1:0]] = 1'b1;
            HALF_WORD: be = req.pa[1] ? 4'b1100 : 4'b0011;
            WORD:      be = 4'b1111;
            default:   be = 4'b0000;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DRAM_WORDS; i++) begin
                mem[i] <= '0;
            end
            busy <= 1'b0;
        end else begin
            busy <= (req.op == DC_W);  // drain cycle after each store
            if (req.op == DC_W) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    // whole word, lane select happens in memory2
    always_ff @(posedge clk) begin
        if (req.op == DC_R) begin
            rdata <= mem[idx];
        end
    end

endmodule

// File: hdl/mem_subsys.sv
`timescale 1ns/1ns

module mem_subsys import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  csr_t                  csr,
    input  execute_memory1_pass_t pass_in,
    input  excp_pass_t            excp_in,
    input  logic                  out_rdy,
    output logic                  in_rdy,
    output load_use_t             ld_use,
    output forward_req_t          fwd_req,
    output wb_pass_t              wb_out,
    output excp_pass_t            excp_out
);

    dcache_req_t           dcache_req;
    logic                  busy;
    u32_t                  rdata;
    memory1_memory2_pass_t pass_mid;
    excp_pass_t            excp_mid;
    logic                  mid_rdy;

    memory1 u_memory1 (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .next_rdy_in   (mid_rdy),
        .dcache_busy   (busy),
        .rd_csr        (csr),
        .pass_in       (pass_in),
        .excp_pass_in  (excp_in),
        .rdy_in        (in_rdy),
        .ld_use        (ld_use),
        .fwd_req       (fwd_req),
        .dcache_req    (dcache_req),
        .pass_out      (pass_mid),
        .excp_pass_out (excp_mid)
    );

    // stands in for the dcache
    data_ram u_data_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (dcache_req),
        .busy  (busy),
        .rdata (rdata)
    );

    memory2 u_memory2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .next_rdy_in  (out_rdy),
        .rdata        (rdata),
        .pass_in      (pass_mid),
        .excp_pass_in (excp_mid),
        .rdy_in       (mid_rdy),
        .wb_out       (wb_out),
        .excp_out     (excp_out)
    );

endmodule

// File: hdl/memory1.sv
`timescale 1ns/1ns

module memory1 import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  next_rdy_in,
    input  logic                  dcache_busy,
    input  csr_t                  rd_csr,
    input  execute_memory1_pass_t pass_in,
    input  excp_pass_t            excp_pass_in,
    output logic                  rdy_in,
    output load_use_t             ld_use,
    output forward_req_t          fwd_req,
    output dcache_req_t           dcache_req,
    output memory1_memory2_pass_t pass_out,
    output excp_pass_t            excp_pass_out
);

    execute_memory1_pass_t pass_in_r;
    excp_pass_t            excp_pass_in_r;

    logic       mem1_flush, mem1_stall, busy_stall;
    logic       rdy_out;
    logic       req_fire;
    u32_t       pa;
    u32_t       st_data;
    excp_pass_t addr_excp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_in_r.valid <= 1'b0;
        end else if (rdy_in) begin
            pass_in_r      <= pass_in;
            excp_pass_in_r <= excp_pass_in;
        end
    end

    assign mem1_flush = flush | ~pass_in_r.valid;
    assign busy_stall = pass_in_r.is_mem & dcache_busy;
    assign mem1_stall = ~next_rdy_in | busy_stall;

    assign rdy_in  = mem1_flush | ~mem1_stall;
    assign rdy_out = ~mem1_flush & ~mem1_stall;

    // hazard info for the issue side
    assign ld_use.valid = pass_in_r.is_mem & ~pass_in_r.is_store & ~mem1_flush;
    assign ld_use.idx   = pass_in_r.rd;

    assign fwd_req.valid = pass_in_r.is_wr_rd & ~mem1_flush;
    assign fwd_req.idx   = pass_in_r.rd;
    assign fwd_req.data  = pass_in_r.is_wr_rd_pc_plus4 ? pass_in_r.pc_plus4 : pass_in_r.ex_out;

    addr_trans u_addr_trans (
        .en        (~mem1_flush & pass_in_r.is_mem),
        .va        (pass_in_r.ex_out),
        .byte_type (pass_in_r.byte_type),
        .rd_csr    (rd_csr),
        .pa        (pa),
        .excp      (addr_excp)
    );

    // one request per item, only on the edge it moves to memory2
    assign req_fire = rdy_out & pass_in_r.is_mem & ~excp_pass_in_r.valid & ~addr_excp.valid;

    always_comb begin
        st_data = pass_in_r.rkd_data;
        case (pass_in_r.byte_type)
            BYTE:      st_data[pa[1:0]*8 +: 8] = pass_in_r.rkd_data[7:0];
            HALF_WORD: st_data[pa[1]*16 +: 16] = pass_in_r.rkd_data[15:0];
            default: ;
        endcase
    end

    assign dcache_req.op        = !req_fire          ? DC_NOP :
                                  pass_in_r.is_store ? DC_W   : DC_R;
    assign dcache_req.byte_type = pass_in_r.byte_type;
    assign dcache_req.pa        = pa;
    assign dcache_req.wdata     = st_data;

    assign pass_out.valid             = rdy_out;
    assign pass_out.pc                = pass_in_r.pc;
    assign pass_out.ex_out            = pass_in_r.ex_out;
    assign pass_out.addr_low          = pa[1:0];
    assign pass_out.is_mem            = pass_in_r.is_mem;
    assign pass_out.is_store          = pass_in_r.is_store;
    assign pass_out.is_signed         = pass_in_r.is_signed;
    assign pass_out.byte_type         = pass_in_r.byte_type;
    assign pass_out.is_wr_rd          = pass_in_r.is_wr_rd;
    assign pass_out.is_wr_rd_pc_plus4 = pass_in_r.is_wr_rd_pc_plus4;
    assign pass_out.pc_plus4          = pass_in_r.pc_plus4;
    assign pass_out.rd                = pass_in_r.rd;

    // earlier stage exception wins over translation
    always_comb begin
        excp_pass_out = addr_excp;
        if (excp_pass_in_r.valid) begin
            excp_pass_out = excp_pass_in_r;
        end
        if (!rdy_out) begin
            excp_pass_out.valid = 1'b0;
        end
    end

endmodule

// File: hdl/memory2.sv
`timescale 1ns/1ns

module memory2 import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  next_rdy_in,
    input  u32_t                  rdata,
    input  memory1_memory2_pass_t pass_in,
    input  excp_pass_t            excp_pass_in,
    output logic                  rdy_in,
    output wb_pass_t              wb_out,
    output excp_pass_t            excp_out
);

    memory1_memory2_pass_t pass_in_r;
    excp_pass_t            excp_pass_in_r;

    logic mem2_flush;
    logic is_load;
    u32_t shifted;
    u32_t ld_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_in_r.valid <= 1'b0;
        end else if (rdy_in) begin
            pass_in_r      <= pass_in;
            excp_pass_in_r <= excp_pass_in;
        end
    end

    assign mem2_flush = flush | ~pass_in_r.valid;
    assign rdy_in     = mem2_flush | next_rdy_in;

    assign is_load = pass_in_r.is_mem & ~pass_in_r.is_store;

    // bring the addressed lane down to bit 0
    assign shifted = rdata >> {pass_in_r.addr_low, 3'b000};

    always_comb begin
        case (pass_in_r.byte_type)
            BYTE: begin
                ld_data = {{24{pass_in_r.is_signed & shifted[7]}}, shifted[7:0]};
            end
            HALF_WORD: begin
                ld_data = {{16{pass_in_r.is_signed & shifted[15]}}, shifted[15:0]};
            end
            default: ld_data = rdata;
        endcase
    end

    assign wb_out.valid    = ~mem2_flush;
    assign wb_out.pc       = pass_in_r.pc;
    assign wb_out.rd       = pass_in_r.rd;
    assign wb_out.is_wr_rd = pass_in_r.is_wr_rd & ~excp_pass_in_r.valid;
    assign wb_out.wr_data  = pass_in_r.is_wr_rd_pc_plus4 ? pass_in_r.pc_plus4 :
                             is_load                     ? ld_data            :
                                                           pass_in_r.ex_out;

    assign excp_out.valid = ~mem2_flush & excp_pass_in_r.valid;
    assign excp_out.ecode = excp_pass_in_r.ecode;
    assign excp_out.badv  = excp_pass_in_r.badv;

endmodule

// File: mem_subsys.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/addr_trans.sv
hdl/memory1.sv
hdl/data_ram.sv
hdl/memory2.sv
hdl/mem_subsys.sv
sim/tb_mem_subsys.sv

// File: sim/tb_mem_subsys.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module tb_mem_subsys import cpu_pkg::*; ();

    localparam int   HALF_PERIOD  = 50;
    localparam int   RESET_CYCLES = 10;
    localparam int   WAIT_LIMIT   = 200;  // cycles
    localparam logic [31:0] SEED  = 32'h1a99679d;

    logic                  clk, rst_n, flush, out_rdy, in_rdy;
    csr_t                  csr;
    execute_memory1_pass_t pass_in;
    excp_pass_t            excp_in, excp_out;
    load_use_t             ld_use;
    forward_req_t          fwd_req;
    wb_pass_t              wb_out;

    u32_t       model [`DRAM_WORDS];  // reference copy of the data array
    wb_pass_t   exp_wb [$];
    excp_pass_t exp_excp [$];
    u32_t       pc_cnt;
    logic       hold_out, rand_rdy;

    mem_subsys UUT (.*);

    always #HALF_PERIOD clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_wb(input wb_pass_t got, input wb_pass_t exp);
        // data only matters when the register is written
        if (got.pc !== exp.pc || got.rd !== exp.rd ||
            got.is_wr_rd !== exp.is_wr_rd || (exp.is_wr_rd && got.wr_data !== exp.wr_data)) begin
            stop_with_error($sformatf(
                "[ERROR] %0t: wb pc %h rd %0d we %b data %h, expected pc %h rd %0d we %b data %h",
                $time, got.pc, got.rd, got.is_wr_rd, got.wr_data,
                exp.pc, exp.rd, exp.is_wr_rd, exp.wr_data));
        end
    endtask

    task automatic check_excp(input excp_pass_t got, input excp_pass_t exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.ecode !== exp.ecode || got.badv !== exp.badv))) begin
            stop_with_error($sformatf(
                "[ERROR] %0t: excp %b ecode %0h badv %h, expected %b ecode %0h badv %h",
                $time, got.valid, got.ecode, got.badv, exp.valid, exp.ecode, exp.badv));
        end
    endtask

    task automatic check_ld_use(input load_use_t got, input load_use_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.idx !== exp.idx)) begin
            stop_with_error($sformatf("[ERROR] %0t: ld_use %b idx %0d, expected %b idx %0d",
                $time, got.valid, got.idx, exp.valid, exp.idx));
        end
    endtask

    task automatic check_fwd(input forward_req_t got, input forward_req_t exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.idx !== exp.idx || got.data !== exp.data))) begin
            stop_with_error($sformatf("[ERROR] %0t: fwd %b idx %0d data %h, expected %b %0d %h",
                $time, got.valid, got.idx, got.data, exp.valid, exp.idx, exp.data));
        end
    endtask

    function automatic execute_memory1_pass_t mk_item(input logic is_mem, input logic is_store,
            input logic sgn, input byte_type_t bt, input u32_t addr, input u32_t data,
            input reg_idx_t rd, input logic pc4);
        execute_memory1_pass_t it;
        it = '0;
        it.valid             = 1'b1;
        it.pc                = pc_cnt;
        it.pc_plus4          = pc_cnt + 32'd4;
        it.ex_out            = addr;
        it.rkd_data          = data;
        it.is_mem            = is_mem;
        it.is_store          = is_store;
        it.is_signed         = sgn;
        it.byte_type         = bt;
        it.is_wr_rd          = !(is_mem && is_store);  // stores write no register
        it.is_wr_rd_pc_plus4 = pc4;
        it.rd                = rd;
        pc_cnt = pc_cnt + 32'd4;
        return it;
    endfunction

    // translation, alignment, memory update and write-back value of one item
    function automatic void predict(input execute_memory1_pass_t it, input excp_pass_t ex_in,
                                    output wb_pass_t wb, output excp_pass_t ex);
        u32_t                va, pa, word, ld;
        logic                hit;
        logic [1:0]          off;
        logic [`DRAM_AW-1:0] w;
        logic [7:0]          b;
        logic [15:0]         h;
        va  = it.ex_out;
        off = va[1:0];
        hit = 1'b1;
        if (csr.da) pa = va;
        else if (csr.dmw0.plv0 && csr.dmw0.vseg == va[31:29]) pa = {csr.dmw0.pseg, va[28:0]};
        else if (csr.dmw1.plv0 && csr.dmw1.vseg == va[31:29]) pa = {csr.dmw1.pseg, va[28:0]};
        else begin
            pa  = va;
            hit = 1'b0;
        end
        ex = '0;
        if (ex_in.valid) ex = ex_in;
        else if (it.is_mem && ((it.byte_type == HALF_WORD && off[0]) ||
                               (it.byte_type == WORD && off != 2'b00))) ex = {1'b1, ECODE_ALE, va};
        else if (it.is_mem && !hit) ex = {1'b1, ECODE_ADEM, va};
        w    = pa[`DRAM_AW+1:2];
        word = model[w];
        if (it.is_mem && it.is_store && !ex.valid) begin
            case (it.byte_type)
                BYTE:      model[w][8*off +: 8]     = it.rkd_data[7:0];
                HALF_WORD: model[w][16*off[1] +: 16] = it.rkd_data[15:0];
                default:   model[w]                 = it.rkd_data;
            endcase
        end
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (it.byte_type)
            BYTE:      ld = it.is_signed ? {{24{b[7]}}, b} : {24'd0, b};
            HALF_WORD: ld = it.is_signed ? {{16{h[15]}}, h} : {16'd0, h};
            default:   ld = word;
        endcase
        wb.valid    = 1'b1;
        wb.pc       = it.pc;
        wb.rd       = it.rd;
        wb.is_wr_rd = it.is_wr_rd && !ex.valid;
        if (it.is_wr_rd_pc_plus4) wb.wr_data = it.pc_plus4;
        else if (it.is_mem && !it.is_store) wb.wr_data = ld;
        else wb.wr_data = it.ex_out;
    endfunction

    task automatic set_out_rdy();
        if (hold_out) out_rdy = 1'b0;
        else if (rand_rdy) out_rdy = ($urandom_range(3) != 0);
        else out_rdy = 1'b1;
    endtask

    task automatic drive_bubble();
        set_out_rdy();
        pass_in.valid = 1'b0;
        excp_in.valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            drive_bubble();
        end
    endtask

    // holds the item on the input until in_rdy shows it is taken
    task automatic send(input execute_memory1_pass_t it, input excp_pass_t ex_in,
                        input logic to_model, input logic to_queue);
        wb_pass_t   wb;
        excp_pass_t ex;
        logic       accepted;
        int         n;
        n        = 0;
        accepted = 1'b0;
        while (!accepted && n < WAIT_LIMIT) begin
            @(negedge clk);
            set_out_rdy();
            pass_in = it;
            excp_in = ex_in;
            #1;
            accepted = in_rdy;
            n++;
        end
        if (!accepted) begin
            stop_with_error("timeout: the DUT did not accept an input item");
        end else if (to_model) begin
            predict(it, ex_in, wb, ex);
            if (to_queue) begin
                exp_wb.push_back(wb);
                exp_excp.push_back(ex);
            end
        end
    endtask

    task automatic store_to(input byte_type_t bt, input u32_t addr, input u32_t data);
        send(mk_item(1'b1, 1'b1, 1'b0, bt, addr, data, '0, 1'b0), '0, 1'b1, 1'b1);
    endtask

    task automatic load_from(input byte_type_t bt, input logic sgn, input u32_t addr,
                             input reg_idx_t rd);
        send(mk_item(1'b1, 1'b0, sgn, bt, addr, '0, rd, 1'b0), '0, 1'b1, 1'b1);
    endtask

    task automatic alu_result(input u32_t val, input reg_idx_t rd, input logic pc4);
        send(mk_item(1'b0, 1'b0, 1'b0, WORD, val, '0, rd, pc4), '0, 1'b1, 1'b1);
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle(1);
        while (exp_wb.size() != 0 && n < WAIT_LIMIT) begin
            idle(1);
            n++;
        end
        if (exp_wb.size() != 0) begin
            stop_with_error("timeout: expected write-backs did not all arrive");
        end
    endtask

    // item sits in memory1 during the cycle after it left the input
    task automatic probe_hazards(input execute_memory1_pass_t it);
        load_use_t    lu;
        forward_req_t fw;
        idle(1);
        #1;
        lu.valid = it.is_mem && !it.is_store;
        lu.idx   = it.rd;
        fw.valid = it.is_wr_rd;
        fw.idx   = it.rd;
        fw.data  = it.is_wr_rd_pc_plus4 ? it.pc_plus4 : it.ex_out;
        check_ld_use(ld_use, lu);
        check_fwd(fwd_req, fw);
    endtask

    // compares each write-back that completes its handshake
    initial begin
        forever begin
            @(negedge clk);
            #(HALF_PERIOD - 1);  // just before the rising edge
            if (rst_n && wb_out.valid && out_rdy) begin
                if (exp_wb.size() == 0) begin
                    stop_with_error($sformatf("[ERROR] %0t: unexpected write-back pc %h",
                                              $time, wb_out.pc));
                end else begin
                    check_wb(wb_out, exp_wb.pop_front());
                    check_excp(excp_out, exp_excp.pop_front());
                end
            end
        end
    end

    initial begin
        execute_memory1_pass_t it;
        excp_pass_t            up_ex;
        logic [31:0]           r;
        u32_t                  addr;
        byte_type_t            bt;
        void'($urandom(SEED));
        clk      = 1'b0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        out_rdy  = 1'b1;
        csr      = '0;
        csr.da   = 1'b1;
        pass_in  = '0;
        excp_in  = '0;
        hold_out = 1'b0;
        rand_rdy = 1'b0;
        pc_cnt   = 32'h1c00_0000;
        for (int i = 0; i < `DRAM_WORDS; i++) model[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        #1;
        if (wb_out.valid || ld_use.valid || fwd_req.valid || !in_rdy) begin
            stop_with_error($sformatf("[ERROR] %0t: outputs not idle after reset", $time));
        end

        // direct mode word traffic and non-memory items
        for (int i = 0; i < 4; i++) store_to(WORD, 32'h40 + 4*i, 32'hc0de_0000 + 32'h1111*i);
        for (int i = 0; i < 4; i++) load_from(WORD, 1'b0, 32'h40 + 4*i, 5'd3);
        alu_result(32'h1234_5678, 5'd4, 1'b0);
        alu_result(32'h0bad_cafe, 5'd1, 1'b1);
        drain();

        // sub-word lanes and extension
        for (int o = 0; o < 4; o++) store_to(BYTE, 32'h80 + o, 32'h80 + 32'h11*o);
        for (int o = 0; o < 4; o++) begin
            load_from(BYTE, 1'b1, 32'h80 + o, 5'd7);
            load_from(BYTE, 1'b0, 32'h80 + o, 5'd8);
        end
        load_from(WORD, 1'b0, 32'h80, 5'd2);
        store_to(HALF_WORD, 32'h84, 32'h1111_8001);
        store_to(HALF_WORD, 32'h86, 32'h2222_7ffe);
        load_from(HALF_WORD, 1'b1, 32'h84, 5'd9);
        load_from(HALF_WORD, 1'b0, 32'h84, 5'd9);
        load_from(HALF_WORD, 1'b1, 32'h86, 5'd9);
        load_from(WORD, 1'b0, 32'h84, 5'd9);
        store_to(WORD, 32'h88, 32'hffff_ffff);
        store_to(BYTE, 32'h89, 32'h0000_0000);
        load_from(WORD, 1'b0, 32'h88, 5'd10);
        drain();

        // mapped windows and address exceptions
        csr.da   = 1'b0;
        csr.dmw0 = {1'b1, 3'b100, 3'b000};
        csr.dmw1 = {1'b1, 3'b101, 3'b001};
        store_to(WORD, 32'ha000_0020, 32'h5a5a_1234);  // same word as 0x8000_0020
        load_from(WORD, 1'b0, 32'h8000_0020, 5'd11);
        load_from(HALF_WORD, 1'b1, 32'h8000_0022, 5'd11);
        load_from(WORD, 1'b0, 32'h4000_0000, 5'd12);
        store_to(WORD, 32'h0000_0024, 32'hffff_ffff);
        load_from(WORD, 1'b0, 32'h8000_0024, 5'd12);
        store_to(HALF_WORD, 32'h8000_0025, 32'h0000_ffff);
        load_from(WORD, 1'b0, 32'ha000_0026, 5'd13);
        up_ex = {1'b1, ECODE_ADEM, 32'h1234_5678};
        it = mk_item(1'b1, 1'b1, 1'b0, HALF_WORD, 32'h8000_0029, 32'hffff_ffff, '0, 1'b0);
        send(it, up_ex, 1'b1, 1'b1);
        load_from(WORD, 1'b0, 32'h8000_0028, 5'd14);
        drain();
        csr.da = 1'b1;

        // mixed stream under random back-pressure
        rand_rdy = 1'b1;
        for (int i = 0; i < 80; i++) begin
            r    = $urandom;
            addr = 32'h100 + {26'd0, r[7:4], 2'b00};
            bt   = r[9] ? WORD : (r[8] ? HALF_WORD : BYTE);
            if (bt == BYTE) addr = addr + {30'd0, r[11:10]};
            else if (bt == HALF_WORD) addr = addr + {30'd0, r[11], 1'b0};
            case (r[14:12])
                3'd0, 3'd1, 3'd2: store_to(bt, addr, $urandom);
                3'd6, 3'd7:       alu_result($urandom, r[20:16], r[22]);
                default:          load_from(bt, r[21], addr, r[20:16]);
            endcase
        end
        drain();
        rand_rdy = 1'b0;

        // flush with both stages full
        hold_out = 1'b1;
        it = mk_item(1'b1, 1'b1, 1'b0, WORD, 32'h60, 32'haaaa_0001, '0, 1'b0);
        send(it, '0, 1'b1, 1'b0);  // reaches memory2 and writes before the flush
        it = mk_item(1'b1, 1'b1, 1'b0, WORD, 32'h64, 32'hbbbb_0002, '0, 1'b0);
        send(it, '0, 1'b0, 1'b0);  // stuck in memory1 and never writes
        idle(1);
        @(negedge clk);
        flush = 1'b1;
        drive_bubble();
        @(negedge clk);
        flush    = 1'b0;
        hold_out = 1'b0;
        drive_bubble();
        load_from(WORD, 1'b0, 32'h60, 5'd5);
        load_from(WORD, 1'b0, 32'h64, 5'd6);
        alu_result(32'h0000_f1f1, 5'd6, 1'b0);
        drain();

        // hazard outputs while the item is in memory1
        it = mk_item(1'b1, 1'b0, 1'b1, HALF_WORD, 32'h42, '0, 5'd7, 1'b0);
        send(it, '0, 1'b1, 1'b1);
        probe_hazards(it);
        it = mk_item(1'b0, 1'b0, 1'b0, WORD, 32'h7777_0000, '0, 5'd15, 1'b1);
        send(it, '0, 1'b1, 1'b1);
        probe_hazards(it);
        it = mk_item(1'b0, 1'b0, 1'b0, WORD, 32'h3333_4444, '0, 5'd16, 1'b0);
        send(it, '0, 1'b1, 1'b1);
        probe_hazards(it);
        it = mk_item(1'b1, 1'b1, 1'b0, WORD, 32'h48, 32'h9999_0000, '0, 1'b0);
        send(it, '0, 1'b1, 1'b1);
        probe_hazards(it);
        drain();

        $display("TEST PASSED");
        $finish;
    end

endmodule
